// File: verilog/sgmii_rx_pkg.sv
package sgmii_rx_pkg;

	////////////////////////////////////////////////////////////
	// Widths with a meaning

	typedef logic [9:0]  symbol_t;
	typedef logic [7:0]  octet_t;
	typedef logic [7:0]  serdes_word_t;
	typedef logic [15:0] err_count_t;
	typedef logic [3:0]  wb_addr_t;
	typedef logic [31:0] wb_data_t;

	////////////////////////////////////////////////////////////
	// Code groups and lock thresholds

	// Comma octet, also first half of every idle ordered set
	localparam octet_t K28_5 = 8'hBC;
	// Start of packet
	localparam octet_t K27_7 = 8'hFB;
	// Terminate
	localparam octet_t K29_7 = 8'hFD;
	// Carrier extend
	localparam octet_t K23_7 = 8'hF7;

	// abcdei of K28.x in its RD- form
	localparam logic [5:0] K28_6B = 6'b001111;

	localparam int COMMA_WINDOW  = 20;
	localparam int LOCK_COMMAS   = 4;
	localparam int UNLOCK_ERRORS = 4;
	localparam int IDLE_COUNT    = 3;

	// Counter widths for the thresholds above
	localparam int WINDOW_W = $clog2(COMMA_WINDOW);
	localparam int LOCK_W   = $clog2(LOCK_COMMAS);
	localparam int UNLOCK_W = $clog2(UNLOCK_ERRORS);
	localparam int IDLE_W   = $clog2(IDLE_COUNT);

	////////////////////////////////////////////////////////////
	// Register map, word addresses

	localparam wb_addr_t REG_STATUS    = 4'h0;
	localparam wb_addr_t REG_DISP_ERR  = 4'h1;
	localparam wb_addr_t REG_SYM_ERR   = 4'h2;
	localparam wb_addr_t REG_FRAME_ERR = 4'h3;
	localparam wb_addr_t REG_CLEAR     = 4'h4;

	typedef struct packed {
		logic   valid;
		logic   is_ctl;
		octet_t data;
		logic   disp_err;
		logic   sym_err;
	} dec_out_t;

	typedef struct packed {
		logic   en;
		logic   er;
		octet_t data;
	} gmii_rx_t;

	typedef enum logic [1:0] {HUNT, SYNC, LOCKED} lock_state_t;

	typedef enum logic [1:0] {IDLE, IN_FRAME, EXTEND} pcs_rx_state_t;

endpackage

// File: verilog/rx_gearbox_8to10.sv
`timescale 1ns/10ps

module rx_gearbox_8to10 (
	input  logic                       symbol_clk,
	input  logic                       reset,
	input  sgmii_rx_pkg::serdes_word_t serdes_data,
	input  logic                       bitslip,
	output logic                       symbol_valid,
	output sgmii_rx_pkg::symbol_t      symbol
);

	// Leftover bits, oldest at bit hold_cnt-1
	logic [9:0]  hold_bits;
	logic [4:0]  hold_cnt;

	// Leftover plus the new word, up to 17 live bits
	logic [17:0] merged;
	logic [4:0]  merged_cnt;
	logic [17:0] aligned;

	////////////////////////////////////////////////////////////
	// Bit accounting

	always_comb begin
		// New word lands below the held bits, first bit on the wire is its MSB
		merged     = {hold_bits, serdes_data};
		// A slip throws away the oldest held bit
		merged_cnt = hold_cnt + 5'd8 - {4'd0, bitslip};
		// Oldest ten live bits moved down to [9:0]
		aligned    = merged >> (merged_cnt - 5'd10);
	end

	////////////////////////////////////////////////////////////
	// Output register

	always_ff @(posedge symbol_clk) begin
		// Only the low bits below the count are ever live
		hold_bits <= merged[9:0];
		symbol    <= aligned[9:0];
		if (reset) begin
			hold_cnt     <= 5'd0;
			symbol_valid <= 1'b0;
		end else if (merged_cnt >= 5'd10) begin
			hold_cnt     <= merged_cnt - 5'd10;
			symbol_valid <= 1'b1;
		end else begin
			hold_cnt     <= merged_cnt;
			symbol_valid <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	// 8 bits in and 10 out per symbol, so at most four symbols back to back
	assert property (@(posedge symbol_clk) disable iff (reset)
		symbol_valid [*4] |=> !symbol_valid)
		else $error("gearbox emitted five symbols in a row");

endmodule

// File: verilog/decode_8b10b.sv
`timescale 1ns/10ps

module decode_8b10b (
	input  logic                   symbol_clk,
	input  logic                   reset,
	input  logic                   symbol_valid,
	input  sgmii_rx_pkg::symbol_t  symbol,
	output sgmii_rx_pkg::dec_out_t dec,
	output logic                   bitslip,
	output logic                   locked
);

	logic [5:0] code6;
	logic [5:0] norm6;
	logic [3:0] code4;
	logic [3:0] norm4;
	logic [2:0] ones6;
	logic [2:0] ones4;
	logic [4:0] dec5;
	logic [2:0] dec3;
	logic       bad6;
	logic       bad4;
	logic       is_ctl_c;
	logic       disp_err_c;
	logic       sym_err_c;
	logic       comma_c;
	logic       bad_c;
	// Running disparity, high means positive
	logic       rd;
	logic       rd_mid;
	logic       rd_next;

	sgmii_rx_pkg::lock_state_t            state;
	logic [sgmii_rx_pkg::WINDOW_W-1:0]    window_cnt;
	logic [sgmii_rx_pkg::LOCK_W-1:0]      comma_cnt;
	logic [sgmii_rx_pkg::UNLOCK_W-1:0]    err_run;

	////////////////////////////////////////////////////////////
	// Code tables

	always_comb begin
		code6 = symbol[9:4];
		code4 = symbol[3:0];
		ones6 = 3'($countones(code6));
		ones4 = 3'($countones(code4));
		// Two-ones forms are complements of the RD- table entries
		norm6 = (ones6 == 3'd2) ? ~code6 : code6;
		// K28 in RD+ form flips the whole 4b part, balanced codes too
		norm4 = (code6 == ~sgmii_rx_pkg::K28_6B) ? ~code4 : code4;
		if ($countones(norm4) == 1)
			norm4 = ~norm4;

		bad6 = 1'b0;
		case (norm6)
			6'b100111: dec5 = 5'd0;
			6'b011101: dec5 = 5'd1;
			6'b101101: dec5 = 5'd2;
			6'b110001: dec5 = 5'd3;
			6'b110101: dec5 = 5'd4;
			6'b101001: dec5 = 5'd5;
			6'b011001: dec5 = 5'd6;
			6'b111000: dec5 = 5'd7;
			6'b000111: dec5 = 5'd7;
			6'b111001: dec5 = 5'd8;
			6'b100101: dec5 = 5'd9;
			6'b010101: dec5 = 5'd10;
			6'b110100: dec5 = 5'd11;
			6'b001101: dec5 = 5'd12;
			6'b101100: dec5 = 5'd13;
			6'b011100: dec5 = 5'd14;
			6'b010111: dec5 = 5'd15;
			6'b011011: dec5 = 5'd16;
			6'b100011: dec5 = 5'd17;
			6'b010011: dec5 = 5'd18;
			6'b110010: dec5 = 5'd19;
			6'b001011: dec5 = 5'd20;
			6'b101010: dec5 = 5'd21;
			6'b011010: dec5 = 5'd22;
			6'b111010: dec5 = 5'd23;
			6'b110011: dec5 = 5'd24;
			6'b100110: dec5 = 5'd25;
			6'b010110: dec5 = 5'd26;
			6'b110110: dec5 = 5'd27;
			6'b001110: dec5 = 5'd28;
			6'b001111: dec5 = 5'd28;
			6'b101110: dec5 = 5'd29;
			6'b011110: dec5 = 5'd30;
			6'b101011: dec5 = 5'd31;
			default: begin
				dec5 = 5'd0;
				bad6 = 1'b1;
			end
		endcase

		bad4 = 1'b0;
		case (norm4)
			4'b1011: dec3 = 3'd0;
			4'b1001: dec3 = 3'd1;
			4'b0101: dec3 = 3'd2;
			4'b1100: dec3 = 3'd3;
			4'b0011: dec3 = 3'd3;
			4'b1101: dec3 = 3'd4;
			4'b1010: dec3 = 3'd5;
			4'b0110: dec3 = 3'd6;
			4'b1110: dec3 = 3'd7;
			4'b0111: dec3 = 3'd7;
			// 0000 and 1111 only
			default: begin
				dec3 = 3'd0;
				bad4 = 1'b1;
			end
		endcase

		sym_err_c = bad6 || bad4;
		// K28.x, or Kx.7 which uses the alternate 7 on 23, 27, 29 and 30
		is_ctl_c = (norm6 == sgmii_rx_pkg::K28_6B)
			|| ((dec5 inside {5'd23, 5'd27, 5'd29, 5'd30})
			&& (code4 == 4'b1000 || code4 == 4'b0111));
	end

	////////////////////////////////////////////////////////////
	// Running disparity

	always_comb begin
		// 6b part, 111000 and 000111 are balanced but still tied to one side
		disp_err_c = 1'b0;
		rd_mid     = rd;
		if (ones6 > 3'd3) begin
			disp_err_c = rd;
			rd_mid     = 1'b1;
		end else if (ones6 < 3'd3) begin
			disp_err_c = !rd;
			rd_mid     = 1'b0;
		end else if (code6 == 6'b111000) begin
			disp_err_c = rd;
		end else if (code6 == 6'b000111) begin
			disp_err_c = !rd;
		end

		// 4b part, same rule with 1100 and 0011
		rd_next = rd_mid;
		if (ones4 > 3'd2) begin
			disp_err_c = disp_err_c || rd_mid;
			rd_next    = 1'b1;
		end else if (ones4 < 3'd2) begin
			disp_err_c = disp_err_c || !rd_mid;
			rd_next    = 1'b0;
		end else if (code4 == 4'b1100) begin
			disp_err_c = disp_err_c || rd_mid;
		end else if (code4 == 4'b0011) begin
			disp_err_c = disp_err_c || !rd_mid;
		end

		comma_c = !sym_err_c && is_ctl_c && ({dec3, dec5} == sgmii_rx_pkg::K28_5);
		bad_c   = sym_err_c || disp_err_c;
	end

	////////////////////////////////////////////////////////////
	// Output register and lock FSM

	always_ff @(posedge symbol_clk) begin
		dec.data   <= {dec3, dec5};
		dec.is_ctl <= is_ctl_c;
		if (reset) begin
			dec.valid    <= 1'b0;
			dec.disp_err <= 1'b0;
			dec.sym_err  <= 1'b0;
			rd           <= 1'b0;
			state        <= sgmii_rx_pkg::HUNT;
			bitslip      <= 1'b0;
			window_cnt   <= '0;
			comma_cnt    <= '0;
			err_run      <= '0;
		end else begin
			dec.valid    <= symbol_valid;
			dec.disp_err <= symbol_valid && disp_err_c;
			dec.sym_err  <= symbol_valid && sym_err_c;
			bitslip      <= 1'b0;
			if (symbol_valid) begin
				rd <= rd_next;
				case (state)
					sgmii_rx_pkg::HUNT: begin
						if (comma_c) begin
							state      <= sgmii_rx_pkg::SYNC;
							comma_cnt  <= 1;
							window_cnt <= '0;
						end else if (int'(window_cnt) == sgmii_rx_pkg::COMMA_WINDOW - 1) begin
							// No comma in this alignment, try one bit later
							bitslip    <= 1'b1;
							window_cnt <= '0;
						end else begin
							window_cnt <= window_cnt + 1'b1;
						end
					end
					sgmii_rx_pkg::SYNC: begin
						if (bad_c) begin
							state      <= sgmii_rx_pkg::HUNT;
							window_cnt <= '0;
						end else if (comma_c) begin
							window_cnt <= '0;
							comma_cnt  <= comma_cnt + 1'b1;
							if (int'(comma_cnt) == sgmii_rx_pkg::LOCK_COMMAS - 1) begin
								state   <= sgmii_rx_pkg::LOCKED;
								err_run <= '0;
							end
						end else if (int'(window_cnt) == sgmii_rx_pkg::COMMA_WINDOW - 1) begin
							// Commas stopped, alignment was a fluke
							state      <= sgmii_rx_pkg::HUNT;
							window_cnt <= '0;
						end else begin
							window_cnt <= window_cnt + 1'b1;
						end
					end
					sgmii_rx_pkg::LOCKED: begin
						if (!bad_c) begin
							err_run <= '0;
						end else if (int'(err_run) == sgmii_rx_pkg::UNLOCK_ERRORS - 1) begin
							state      <= sgmii_rx_pkg::HUNT;
							window_cnt <= '0;
						end else begin
							err_run <= err_run + 1'b1;
						end
					end
					default: state <= sgmii_rx_pkg::HUNT;
				endcase
			end
		end
	end

	assign locked = (state == sgmii_rx_pkg::LOCKED);

	// Slips only come out of HUNT, a slip at lock would break the PCS stream
	assert property (@(posedge symbol_clk) disable iff (reset) bitslip |-> !locked)
		else $error("bitslip while locked");

endmodule

// File: verilog/gmii_rx_pcs.sv
`timescale 1ns/10ps

module gmii_rx_pcs (
	input  logic                   symbol_clk,
	input  logic                   reset,
	input  sgmii_rx_pkg::dec_out_t dec,
	input  logic                   locked,
	output sgmii_rx_pkg::gmii_rx_t gmii_rx,
	output logic                   link_up,
	output logic                   frame_err
);

	sgmii_rx_pkg::pcs_rx_state_t     state;
	logic [sgmii_rx_pkg::IDLE_W-1:0] idle_cnt;
	// Last valid symbol was a clean K28.5
	logic                            prev_comma;

	logic clean;
	logic is_comma;
	logic idle_os;
	logic start_c;
	logic term_c;
	logic ext_c;

	////////////////////////////////////////////////////////////
	// Symbol classes

	always_comb begin
		clean    = dec.valid && !dec.sym_err;
		is_comma = clean && dec.is_ctl && (dec.data == sgmii_rx_pkg::K28_5);
		// K28.5 then a data octet, covers both I1 and I2
		idle_os  = clean && !dec.is_ctl && prev_comma;
		start_c  = clean && dec.is_ctl && (dec.data == sgmii_rx_pkg::K27_7);
		term_c   = clean && dec.is_ctl && (dec.data == sgmii_rx_pkg::K29_7);
		ext_c    = clean && dec.is_ctl && (dec.data == sgmii_rx_pkg::K23_7);
	end

	////////////////////////////////////////////////////////////
	// Link and framing

	always_ff @(posedge symbol_clk) begin
		gmii_rx.data <= dec.data;
		// Losing lock tears down the link and any frame in flight
		if (reset || !locked) begin
			state      <= sgmii_rx_pkg::IDLE;
			idle_cnt   <= '0;
			prev_comma <= 1'b0;
			link_up    <= 1'b0;
			gmii_rx.en <= 1'b0;
			gmii_rx.er <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			gmii_rx.en <= 1'b0;
			gmii_rx.er <= 1'b0;
			frame_err  <= 1'b0;
			if (dec.valid) begin
				prev_comma <= is_comma;

				// Link up after enough back to back idle ordered sets
				if (!link_up) begin
					if (idle_os) begin
						if (int'(idle_cnt) == sgmii_rx_pkg::IDLE_COUNT - 1)
							link_up <= 1'b1;
						else
							idle_cnt <= idle_cnt + 1'b1;
					end else if (!is_comma) begin
						idle_cnt <= '0;
					end
				end

				case (state)
					sgmii_rx_pkg::IN_FRAME: begin
						if (term_c) begin
							state <= sgmii_rx_pkg::EXTEND;
						end else if (dec.sym_err || dec.is_ctl) begin
							gmii_rx.en <= 1'b1;
							gmii_rx.er <= 1'b1;
							frame_err  <= 1'b1;
							// A comma means the terminate went missing
							if (is_comma)
								state <= sgmii_rx_pkg::IDLE;
						end else begin
							gmii_rx.en <= 1'b1;
						end
					end
					sgmii_rx_pkg::EXTEND: begin
						// Carrier extend after terminate is dropped silently
						if (start_c)
							state <= sgmii_rx_pkg::IN_FRAME;
						else if (!ext_c)
							state <= sgmii_rx_pkg::IDLE;
					end
					default: begin
						// Start code itself never reaches GMII
						if (start_c && link_up)
							state <= sgmii_rx_pkg::IN_FRAME;
					end
				endcase
			end
		end
	end

	assert property (@(posedge symbol_clk) disable iff (reset) gmii_rx.en |-> link_up)
		else $error("GMII data while link is down");

endmodule

// File: verilog/sgmii_rx_status_wb.sv
`timescale 1ns/10ps

module sgmii_rx_status_wb (
	input  logic                   symbol_clk,
	input  logic                   reset,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  sgmii_rx_pkg::wb_addr_t wb_adr,
	input  sgmii_rx_pkg::wb_data_t wb_dat_w,
	output sgmii_rx_pkg::wb_data_t wb_dat_r,
	output logic                   wb_ack,
	input  logic                   dec_disp_err,
	input  logic                   dec_sym_err,
	input  logic                   frame_err,
	input  logic                   locked,
	input  logic                   link_up
);

	// 0 disparity, 1 code, 2 frame
	sgmii_rx_pkg::err_count_t count [3];
	logic [2:0]               events;
	// New access, not the tail of one already acked
	logic                     strobe;
	logic                     clear;

	assign events = {frame_err, dec_sym_err, dec_disp_err};
	assign strobe = wb_cyc && wb_stb && !wb_ack;
	// Bit 0 of the write data is the clear command
	assign clear  = strobe && wb_we && (wb_adr == sgmii_rx_pkg::REG_CLEAR) && wb_dat_w[0];

	////////////////////////////////////////////////////////////
	// Error counters, stuck at all ones

	always_ff @(posedge symbol_clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			for (int i = 0; i < 3; i++)
				count[i] <= '0;
		end else begin
			wb_ack <= strobe;
			for (int i = 0; i < 3; i++) begin
				if (clear)
					count[i] <= '0;
				else if (events[i] && (count[i] != '1))
					count[i] <= count[i] + 1'b1;
			end
		end
	end

	// Read mux, held until the next access
	always_ff @(posedge symbol_clk) begin
		if (strobe) begin
			case (wb_adr)
				sgmii_rx_pkg::REG_STATUS:    wb_dat_r <= {30'd0, link_up, locked};
				sgmii_rx_pkg::REG_DISP_ERR:  wb_dat_r <= {16'd0, count[0]};
				sgmii_rx_pkg::REG_SYM_ERR:   wb_dat_r <= {16'd0, count[1]};
				sgmii_rx_pkg::REG_FRAME_ERR: wb_dat_r <= {16'd0, count[2]};
				default:                     wb_dat_r <= '0;
			endcase
		end
	end

	assert property (@(posedge symbol_clk) disable iff (reset) wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("ack without a strobe");

endmodule

// File: verilog/sgmii_rx_bridge.sv
`timescale 1ns/10ps

module sgmii_rx_bridge (
	input  logic                       symbol_clk,
	input  logic                       reset,
	input  sgmii_rx_pkg::serdes_word_t serdes_data,
	output sgmii_rx_pkg::gmii_rx_t     gmii_rx,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  sgmii_rx_pkg::wb_addr_t     wb_adr,
	input  sgmii_rx_pkg::wb_data_t     wb_dat_w,
	output sgmii_rx_pkg::wb_data_t     wb_dat_r,
	output logic                       wb_ack
);

	logic                   symbol_valid;
	sgmii_rx_pkg::symbol_t  symbol;
	logic                   bitslip;
	sgmii_rx_pkg::dec_out_t dec;
	logic                   locked;
	logic                   link_up;
	logic                   frame_err;

	////////////////////////////////////////////////////////////
	// Receive pipeline

	// SERDES words to 10-bit symbols, slipped by the decoder
	rx_gearbox_8to10 i_gearbox (
		.symbol_clk   (symbol_clk),
		.reset        (reset),
		.serdes_data  (serdes_data),
		.bitslip      (bitslip),
		.symbol_valid (symbol_valid),
		.symbol       (symbol)
	);

	decode_8b10b i_decoder (
		.symbol_clk   (symbol_clk),
		.reset        (reset),
		.symbol_valid (symbol_valid),
		.symbol       (symbol),
		.dec          (dec),
		.bitslip      (bitslip),
		.locked       (locked)
	);

	gmii_rx_pcs i_pcs (
		.symbol_clk (symbol_clk),
		.reset      (reset),
		.dec        (dec),
		.locked     (locked),
		.gmii_rx    (gmii_rx),
		.link_up    (link_up),
		.frame_err  (frame_err)
	);

	////////////////////////////////////////////////////////////
	// Status registers

	sgmii_rx_status_wb i_status (
		.symbol_clk   (symbol_clk),
		.reset        (reset),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.dec_disp_err (dec.disp_err),
		.dec_sym_err  (dec.sym_err),
		.frame_err    (frame_err),
		.locked       (locked),
		.link_up      (link_up)
	);

endmodule

// File: verification/enc_8b10b_model.svh
`ifndef ENC_8B10B_MODEL_SVH
`define ENC_8B10B_MODEL_SVH

	////////////////////////////////////////////////////////////
	// 8b/10b encoder with running disparity

	// Encoder disparity, high means positive
	logic model_rd;
	// Line bits waiting to be sent, first bit on the wire at the front
	logic bit_q[$];

	// 5b/6b code in its RD- form, abcdei with a as MSB
	function automatic logic [5:0] six_code(input logic [4:0] x);
		logic [5:0] tbl [32];
		tbl = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001,
			6'b011001, 6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100,
			6'b001101, 6'b101100, 6'b011100, 6'b010111, 6'b011011, 6'b100011,
			6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
			6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110,
			6'b011110, 6'b101011};
		return tbl[x];
	endfunction

	// 3b/4b code for the disparity in front of it, alt picks the A7 form
	function automatic logic [3:0] four_code(input logic [2:0] y, input logic rd_mid,
		input logic alt);
		logic [3:0] tbl [8];
		logic [3:0] code;
		tbl  = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
		code = (alt && y == 3'd7) ? 4'b0111 : tbl[y];
		// RD+ takes the complement of unbalanced codes and of 1100
		if (rd_mid && ($countones(code) != 2 || code == 4'b1100))
			code = ~code;
		return code;
	endfunction

	function automatic logic [9:0] encode_symbol(input logic [7:0] octet, input logic is_ctl);
		logic [4:0] x;
		logic [2:0] y;
		logic [5:0] six;
		logic [3:0] four;
		logic       rd_mid;
		logic       alt;
		logic [9:0] sym;
		x = octet[4:0];
		y = octet[7:5];
		if (is_ctl && x == 5'd28) begin
			// K28.y built in RD- form, whole group inverted for RD+
			sym = {6'b001111, four_code(y, 1'b1, 1'b1)};
			if (model_rd)
				sym = ~sym;
		end else begin
			six    = six_code(x);
			rd_mid = model_rd;
			if ($countones(six) != 3)
				rd_mid = !model_rd;
			if (model_rd && ($countones(six) != 3 || six == 6'b111000))
				six = ~six;
			// Kx.7 always A7, data only for the six codes that would run long
			alt  = is_ctl || (!rd_mid && x inside {5'd17, 5'd18, 5'd20})
				|| (rd_mid && x inside {5'd11, 5'd13, 5'd14});
			four = four_code(y, rd_mid, alt);
			sym  = {six, four};
		end
		if ($countones(sym) != 5)
			model_rd = !model_rd;
		return sym;
	endfunction

	// Right code in the wrong disparity, 6b part inverted and RD left alone
	function automatic logic [9:0] flip_symbol(input logic [7:0] octet);
		logic       saved_rd;
		logic [9:0] sym;
		saved_rd   = model_rd;
		sym        = encode_symbol(octet, 1'b0);
		model_rd   = saved_rd;
		sym[9:4]   = ~sym[9:4];
		return sym;
	endfunction

	// 4b part 0000 or 1111 never exists, picked so the disparity stays legal
	function automatic logic [9:0] invalid_symbol();
		logic [9:0] sym;
		sym      = {6'b110001, model_rd ? 4'b0000 : 4'b1111};
		model_rd = !model_rd;
		return sym;
	endfunction

	////////////////////////////////////////////////////////////
	// Serializer

	function automatic void push_symbol(input logic [9:0] sym);
		for (int i = 9; i >= 0; i--)
			bit_q.push_back(sym[i]);
	endfunction

	// Eight line bits, first one in the MSB
	function automatic logic [7:0] pop_word();
		logic [7:0] w;
		for (int i = 7; i >= 0; i--)
			w[i] = bit_q.pop_front();
		return w;
	endfunction

`endif

// File: verification/sgmii_rx_bridge_tb.sv
`timescale 1ns/10ps

module sgmii_rx_bridge_tb;

	localparam int KIND_DATA = 0;
	localparam int KIND_CTL  = 1;
	localparam int KIND_DISP = 2;
	localparam int KIND_BAD  = 3;
	localparam int TIMEOUT   = 400;

	typedef struct packed {
		logic [1:0]           kind;
		sgmii_rx_pkg::octet_t octet;
		logic                 exp_en;
		logic                 exp_er;
	} stim_entry_t;

	logic                       symbol_clk;
	logic                       reset;
	sgmii_rx_pkg::serdes_word_t serdes_data;
	sgmii_rx_pkg::gmii_rx_t     gmii_rx;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	sgmii_rx_pkg::wb_addr_t     wb_adr;
	sgmii_rx_pkg::wb_data_t     wb_dat_w;
	sgmii_rx_pkg::wb_data_t     wb_dat_r;
	logic                       wb_ack;

	int          seed;
	int          offset;
	int          idle_sets_sent;
	stim_entry_t stim[$];
	int          seg_first[$];
	// {er, data} per GMII byte
	logic [8:0]  exp_q[$];
	logic [8:0]  rx_q[$];

	`include "enc_8b10b_model.svh"

	sgmii_rx_bridge i_dut (
		.symbol_clk  (symbol_clk),
		.reset       (reset),
		.serdes_data (serdes_data),
		.gmii_rx     (gmii_rx),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack)
	);

	always #10 symbol_clk = ~symbol_clk;

	// Line driver, fills gaps with idle ordered sets K28.5 D16.2
	always @(negedge symbol_clk) begin
		if (bit_q.size() < 20) begin
			push_symbol(encode_symbol(sgmii_rx_pkg::K28_5, 1'b1));
			push_symbol(encode_symbol(8'h50, 1'b0));
			idle_sets_sent++;
		end
		serdes_data <= pop_word();
	end

	// GMII monitor, outputs settle after the rising edge
	always @(negedge symbol_clk) begin
		if (!reset && gmii_rx.en)
			rx_q.push_back({gmii_rx.er, gmii_rx.data});
	end

	////////////////////////////////////////////////////////////
	// Checks and waits

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			stop_run($sformatf("mismatch at %0d ns: %s, got %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	task automatic wait_idle_sets(input int n);
		int target;
		int cycles;
		target = idle_sets_sent + n;
		cycles = 0;
		while (idle_sets_sent < target) begin
			@(negedge symbol_clk);
			cycles++;
			if (cycles > TIMEOUT)
				stop_run("timeout, the line never went back to idle");
		end
	endtask

	// One classic cycle, ack must come once and then go away
	task automatic wb_access(input logic we, input sgmii_rx_pkg::wb_addr_t addr,
		input sgmii_rx_pkg::wb_data_t wdata, output sgmii_rx_pkg::wb_data_t rdata);
		int cycles;
		@(negedge symbol_clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = addr;
		wb_dat_w = wdata;
		cycles   = 0;
		do begin
			@(negedge symbol_clk);
			cycles++;
			if (cycles > 16)
				stop_run("timeout, Wishbone access got no ack");
		end while (!wb_ack);
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge symbol_clk);
		check_value(wb_ack, 1'b0, "second ack on one access");
	endtask

	// Status is read at least once, even when the wanted bits are zero
	task automatic wait_status(input logic [1:0] want, input string what);
		sgmii_rx_pkg::wb_data_t d;
		int                     tries;
		tries = 0;
		do begin
			wb_access(1'b0, sgmii_rx_pkg::REG_STATUS, '0, d);
			tries++;
			if (tries > TIMEOUT)
				stop_run($sformatf("timeout waiting for %s", what));
		end while (d[1:0] != want);
	endtask

	task automatic check_counters(input int disp, input int sym, input int frame);
		sgmii_rx_pkg::wb_data_t d;
		wb_access(1'b0, sgmii_rx_pkg::REG_DISP_ERR, '0, d);
		check_value(d, disp, "disparity error count");
		wb_access(1'b0, sgmii_rx_pkg::REG_SYM_ERR, '0, d);
		check_value(d, sym, "code error count");
		wb_access(1'b0, sgmii_rx_pkg::REG_FRAME_ERR, '0, d);
		check_value(d, frame, "frame error count");
	endtask

	task automatic clear_counters();
		sgmii_rx_pkg::wb_data_t d;
		wb_access(1'b1, sgmii_rx_pkg::REG_CLEAR, 32'h1, d);
	endtask

	// Every expected byte in order, then nothing extra once the line idles
	task automatic check_received();
		int cycles;
		cycles = 0;
		while (rx_q.size() < exp_q.size()) begin
			@(negedge symbol_clk);
			cycles++;
			if (cycles > TIMEOUT)
				stop_run("timeout, GMII bytes missing");
		end
		wait_idle_sets(4);
		check_value(rx_q.size(), exp_q.size(), "GMII byte count");
		foreach (exp_q[i]) begin
			check_value(rx_q[i][8], exp_q[i][8], $sformatf("er of byte %0d", i));
			// Data under er is whatever the bad group decoded to
			if (!exp_q[i][8])
				check_value(rx_q[i][7:0], exp_q[i][7:0], $sformatf("data of byte %0d", i));
		end
		exp_q.delete();
		rx_q.delete();
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus table

	task automatic add_entry(input int kind, input logic [7:0] octet, input logic en,
		input logic er);
		stim.push_back('{kind[1:0], octet, en, er});
	endtask

	task automatic build_table();
		// 0 clean frame with a carrier extend after terminate
		seg_first.push_back(stim.size());
		add_entry(KIND_CTL, sgmii_rx_pkg::K27_7, 0, 0);
		for (int i = 0; i < 16; i++)
			add_entry(KIND_DATA, 8'($random(seed)), 1, 0);
		add_entry(KIND_CTL, sgmii_rx_pkg::K29_7, 0, 0);
		add_entry(KIND_CTL, sgmii_rx_pkg::K23_7, 0, 0);
		// 1 D.0.1 in the wrong disparity
		seg_first.push_back(stim.size());
		add_entry(KIND_DISP, 8'h20, 0, 0);
		// 2 invalid group between idles
		seg_first.push_back(stim.size());
		add_entry(KIND_BAD, 8'h00, 0, 0);
		// 3 frame broken in the middle
		seg_first.push_back(stim.size());
		add_entry(KIND_CTL, sgmii_rx_pkg::K27_7, 0, 0);
		for (int i = 0; i < 4; i++)
			add_entry(KIND_DATA, 8'h10 + 8'(i), 1, 0);
		add_entry(KIND_BAD, 8'h00, 1, 1);
		for (int i = 0; i < 4; i++)
			add_entry(KIND_DATA, 8'hA0 + 8'(i), 1, 0);
		add_entry(KIND_CTL, sgmii_rx_pkg::K29_7, 0, 0);
		// 4 run of bad groups, long enough to lose lock
		seg_first.push_back(stim.size());
		for (int i = 0; i < 4; i++)
			add_entry(KIND_BAD, 8'h00, 0, 0);
		seg_first.push_back(stim.size());
	endtask

	task automatic apply_segment(input int seg);
		stim_entry_t e;
		@(negedge symbol_clk);
		for (int i = seg_first[seg]; i < seg_first[seg + 1]; i++) begin
			e = stim[i];
			case (e.kind)
				KIND_CTL:  push_symbol(encode_symbol(e.octet, 1'b1));
				KIND_DISP: push_symbol(flip_symbol(e.octet));
				KIND_BAD:  push_symbol(invalid_symbol());
				default:   push_symbol(encode_symbol(e.octet, 1'b0));
			endcase
			if (e.exp_en)
				exp_q.push_back({e.exp_er, e.octet});
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		symbol_clk     = 1'b0;
		reset          = 1'b1;
		serdes_data    = '0;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_adr         = '0;
		wb_dat_w       = '0;
		idle_sets_sent = 0;
		model_rd       = 1'b0;
		seed           = 32'h2cfd97d0;
		// Filler bits put the first symbol at a random bit position
		offset = {$random(seed)} % 10;
		for (int i = 0; i < offset; i++)
			bit_q.push_back(1'b0);
		build_table();

		repeat (5) @(negedge symbol_clk);
		reset = 1'b0;

		wait_status(2'b11, "lock and link up");
		clear_counters();
		check_counters(0, 0, 0);

		apply_segment(0);
		check_received();
		check_counters(0, 0, 0);

		apply_segment(1);
		wait_idle_sets(4);
		check_counters(1, 0, 0);

		apply_segment(2);
		wait_idle_sets(4);
		check_counters(1, 1, 0);

		apply_segment(3);
		check_received();
		check_counters(1, 2, 1);

		apply_segment(4);
		wait_status(2'b00, "lock loss");
		wait_status(2'b11, "lock and link up again");
		check_counters(1, 6, 1);

		clear_counters();
		check_counters(0, 0, 0);

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: sgmii_rx_bridge.f
+incdir+verification
verilog/sgmii_rx_pkg.sv
verilog/rx_gearbox_8to10.sv
verilog/decode_8b10b.sv
verilog/gmii_rx_pcs.sv
verilog/sgmii_rx_status_wb.sv
verilog/sgmii_rx_bridge.sv
verification/sgmii_rx_bridge_tb.sv

// File: Bender.yml
package:
  name: sgmii_rx_bridge

sources:
  - files:
      - verilog/sgmii_rx_pkg.sv
      - verilog/rx_gearbox_8to10.sv
      - verilog/decode_8b10b.sv
      - verilog/gmii_rx_pcs.sv
      - verilog/sgmii_rx_status_wb.sv
      - verilog/sgmii_rx_bridge.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/sgmii_rx_bridge_tb.sv
